// File: build.f
hdl/mem_ctl_pkg.sv
hdl/instr_decoder.sv
hdl/maint_req_queue.sv
hdl/maint_sequencer.sv
hdl/mem_ctl_top.sv
bench/mem_ctl_properties.sv
bench/mem_ctl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module mem_ctl_tb -f build.f -o mem_ctl_sim

status=0
./obj_dir/mem_ctl_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Result: FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation finished without failures"

// File: bench/mem_ctl_tb.sv
/* Load/store control front end testbench */
`timescale 1ns/1ns

module mem_ctl_tb;

	localparam int CLK_PERIOD = 20;
	localparam int N_DECODE   = 40;
	localparam int N_MAINT    = 24;
	localparam int N_EXCEPT   = 16;
	localparam int N_BACKPR   = 12;
	// Up to 8 sync cycles plus queueing per item
	localparam int WORST_LAT  = 16;
	localparam int TIMEOUT_NS =
		((1 + N_DECODE + N_MAINT + N_EXCEPT + N_BACKPR) * WORST_LAT + 100) * CLK_PERIOD;

	logic                         clk_i;
	logic                         rst_n_i;
	logic                         ins_valid_i;
	logic [mem_ctl_pkg::ILEN-1:0] ins_i;
	logic                         except_valid_i;
	mem_ctl_pkg::except_code_e    except_code_i;
	logic                         l2c_update_done_i;
	logic                         stall_o;
	logic                         exec_valid_o;
	mem_ctl_pkg::exec_hint_t      exec_hint_o;
	logic                         maint_valid_o;
	mem_ctl_pkg::maint_cmd_t      maint_cmd_o;

	// Expected responses in acceptance order
	mem_ctl_pkg::exec_hint_t hint_q[$];
	int                      hint_cycle_q[$];
	string                   hint_tag_q[$];
	mem_ctl_pkg::maint_cmd_t cmd_q[$];
	string                   cmd_tag_q[$];
	mem_ctl_pkg::exec_hint_t exp_hint;
	mem_ctl_pkg::maint_cmd_t exp_cmd;
	string                   exp_tag;
	int                      cycle = 0;
	int                      mismatch_count = 0;
	int                      other_count = 0;
	int                      l2_delay;
	logic                    l2_hold = 1'b0;
	logic                    saw_stall = 1'b0;

	mem_ctl_top mem_ctl_top_i (.*);

	bind mem_ctl_top mem_ctl_properties mem_ctl_properties_i (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.stall_i           (stall_o),
		.wr_ptr_i          (maint_req_queue_i.wr_ptr),
		.exec_valid_i      (exec_valid_o),
		.maint_valid_i     (maint_valid_o),
		.maint_cmd_i       (maint_cmd_o),
		.l2c_update_done_i (l2c_update_done_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	always @(posedge clk_i) cycle++;

	// Expected hint and command from the RISC-V encodings
	function automatic void predict(input logic is_exc, input logic [31:0] ins,
		input logic [3:0] code, output logic has_hint, output mem_ctl_pkg::exec_hint_t hint,
		output logic has_cmd, output mem_ctl_pkg::maint_cmd_t cmd);
		logic [6:0] opc;
		logic [2:0] f3;
		opc      = ins[6:0];
		f3       = ins[14:12];
		hint     = '{branch_type: mem_ctl_pkg::BR_BEQ, ldst_type: mem_ctl_pkg::LS_WORD,
			is_branch: 1'b0};
		cmd      = '0;
		has_hint = 1'b0;
		has_cmd  = 1'b0;
		if (is_exc) begin
			has_cmd   = 1'b1;
			cmd.flush = 1'b1;
			case (code)
				4'd0, 4'd1, 4'd12: cmd.clr_tlb_mshr = 1'b1;
				4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15: cmd.clr_dmshr = 1'b1;
				4'd2: cmd.abort = 1'b1;
				4'd9, 4'd11: cmd.sync_l1dc_l2c = 1'b1;
				default: ;
			endcase
		end else if (opc == 7'b1100011) begin
			has_hint       = 1'b1;
			hint.is_branch = 1'b1;
			case (f3)
				3'd1: hint.branch_type = mem_ctl_pkg::BR_BNE;
				3'd4: hint.branch_type = mem_ctl_pkg::BR_BLT;
				3'd5: hint.branch_type = mem_ctl_pkg::BR_BGE;
				3'd6: hint.branch_type = mem_ctl_pkg::BR_BLTU;
				3'd7: hint.branch_type = mem_ctl_pkg::BR_BGEU;
				default: ;
			endcase
		end else if (opc == 7'b0000011 || opc == 7'b0100011) begin
			has_hint = 1'b1;
			// opc[5] set means store, which has no unsigned widths
			case ({opc[5], f3})
				4'b0000, 4'b1000: hint.ldst_type = mem_ctl_pkg::LS_BYTE;
				4'b0001, 4'b1001: hint.ldst_type = mem_ctl_pkg::LS_HALFWORD;
				4'b0011, 4'b1011: hint.ldst_type = mem_ctl_pkg::LS_DOUBLEWORD;
				4'b0100: hint.ldst_type = mem_ctl_pkg::LS_BYTE_U;
				4'b0101: hint.ldst_type = mem_ctl_pkg::LS_HALFWORD_U;
				4'b0110: hint.ldst_type = mem_ctl_pkg::LS_WORD_U;
				default: ;
			endcase
		end else if ((opc == 7'b0001111 && f3 == 3'd1) || (opc == 7'b1110011 && f3 == 3'd0)) begin
			has_cmd          = 1'b1;
			cmd.clr_tlb_mshr = 1'b1;
			if (opc[4]) begin
				cmd.clr_dmshr     = 1'b1;
				cmd.tlb_flush     = mem_ctl_pkg::TLB_FLUSH_ALL;
				cmd.sync_l1dc_l2c = 1'b1;
			end
		end
	endfunction

	// Kinds 0..2 branch, load, store, 3 FENCE.I, 4 SFENCE.VMA, else neither
	function automatic logic [31:0] random_word(input int kind);
		logic [31:0] w;
		w = $urandom;
		case (kind)
			0: w[6:0] = 7'b1100011;
			1: w[6:0] = 7'b0000011;
			2: w[6:0] = 7'b0100011;
			3: w = {w[31:15], 3'b001, w[11:7], 7'b0001111};
			4: w = {w[31:15], 3'b000, w[11:7], 7'b1110011};
			default: begin
				while (w[6:0] inside {7'b1100011, 7'b0000011, 7'b0100011} ||
					(w[6:0] == 7'b0001111 && w[14:12] == 3'b001) ||
					(w[6:0] == 7'b1110011 && w[14:12] == 3'b000)) begin
					w = $urandom;
				end
			end
		endcase
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			mismatch_count++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Drives one cycle of strobes and records what the DUT owes for them
	task automatic offer(input logic ins_v, input logic [31:0] ins, input logic exc_v,
		input logic [3:0] code, input string tag);
		logic                    has_hint;
		logic                    has_cmd;
		mem_ctl_pkg::exec_hint_t hint;
		mem_ctl_pkg::maint_cmd_t cmd;
		ins_valid_i    = ins_v;
		ins_i          = ins;
		except_valid_i = exc_v;
		except_code_i  = mem_ctl_pkg::except_code_e'(code);
		predict(exc_v, ins, code, has_hint, hint, has_cmd, cmd);
		if (stall_o) begin
			saw_stall = 1'b1;
		end else begin
			if (ins_v && has_hint) begin
				hint_q.push_back(hint);
				hint_cycle_q.push_back(cycle + 1);
				hint_tag_q.push_back(tag);
			end
			if ((ins_v || exc_v) && has_cmd) begin
				cmd_q.push_back(cmd);
				cmd_tag_q.push_back(tag);
			end
		end
		@(negedge clk_i);
		ins_valid_i    = 1'b0;
		except_valid_i = 1'b0;
	endtask

	task automatic drain();
		while (hint_q.size() != 0 || cmd_q.size() != 0 || maint_cmd_o.sync_l1dc_l2c) begin
			@(negedge clk_i);
		end
		repeat (2) @(negedge clk_i);
	endtask

	always @(negedge clk_i) begin
		if (rst_n_i && exec_valid_o) begin
			if (hint_q.size() == 0) begin
				other_count++;
				$display("Unexpected execution hint %h in cycle %0d", exec_hint_o, cycle);
			end else begin
				exp_hint = hint_q.pop_front();
				exp_tag  = hint_tag_q.pop_front();
				check_value({exp_tag, " hint"}, 32'(exp_hint), 32'(exec_hint_o));
				check_value({exp_tag, " hint cycle"}, hint_cycle_q.pop_front(), cycle);
			end
		end
		if (rst_n_i && maint_valid_o) begin
			if (cmd_q.size() == 0) begin
				other_count++;
				$display("Unexpected maintenance command %h in cycle %0d", maint_cmd_o, cycle);
			end else begin
				exp_cmd = cmd_q.pop_front();
				exp_tag = cmd_tag_q.pop_front();
				check_value({exp_tag, " command"}, 32'(exp_cmd), 32'(maint_cmd_o));
			end
		end
		// A full queue needs at least a queue depth of commands still owed
		if (rst_n_i && stall_o && cmd_q.size() < mem_ctl_pkg::QUEUE_DEPTH) begin
			other_count++;
			$display("stall_o high with only %0d commands outstanding in cycle %0d",
				cmd_q.size(), cycle);
		end
	end

	// L2 answers a held sync after 1 to 8 cycles
	initial begin
		l2c_update_done_i = 1'b0;
		forever begin
			@(negedge clk_i);
			if (rst_n_i && maint_cmd_o.sync_l1dc_l2c && !l2_hold) begin
				l2_delay = $urandom_range(8, 1);
				repeat (l2_delay) @(negedge clk_i);
				l2c_update_done_i = 1'b1;
				@(negedge clk_i);
				l2c_update_done_i = 1'b0;
			end
		end
	end

	initial begin
		int kind;
		void'($urandom(32'h1f7a_f1a1));
		rst_n_i        = 1'b0;
		ins_valid_i    = 1'b0;
		ins_i          = '0;
		except_valid_i = 1'b0;
		except_code_i  = mem_ctl_pkg::EXC_I_MISALIGNED;
		repeat (4) @(negedge clk_i);
		cmd_q.push_back('{flush: 1'b1, abort: 1'b0, clr_tlb_mshr: 1'b1, clr_dmshr: 1'b1,
			sync_l1dc_l2c: 1'b0, tlb_flush: mem_ctl_pkg::TLB_FLUSH_ALL});
		cmd_tag_q.push_back("reset_cleanup");
		rst_n_i = 1'b1;
		drain();

		for (int k = 0; k < N_DECODE; k++) begin
			kind = $urandom_range(3, 0);
			offer(1'b1, random_word(kind == 3 ? 5 : kind), 1'b0, 4'd0, "decode");
		end
		drain();

		for (int k = 0; k < N_MAINT; k++) begin
			offer(1'b1, random_word($urandom_range(4, 3)), 1'b0, 4'd0, "maint_order");
			repeat ($urandom_range(2, 0)) @(negedge clk_i);
		end
		drain();

		// Every code once, half of them with an instruction that must be dropped
		for (int k = 0; k < N_EXCEPT; k++) begin
			while (stall_o) @(negedge clk_i);
			offer(k[0], random_word($urandom_range(5, 0)), 1'b1, 4'(k), "exception");
		end
		drain();

		saw_stall = 1'b0;
		l2_hold   = 1'b1;
		offer(1'b1, random_word(4), 1'b0, 4'd0, "backpressure");
		for (int k = 0; k < N_BACKPR; k++) begin
			offer(1'b1, random_word(k % 6), k % 3 == 2, 4'($urandom), "backpressure");
		end
		if (!saw_stall) begin
			other_count++;
			$display("stall_o never went high while the L2 was held");
		end
		l2_hold = 1'b0;
		drain();

		$display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns with %0d hints and %0d commands still expected",
			TIMEOUT_NS, hint_q.size(), cmd_q.size());
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: bench/mem_ctl_properties.sv
/* Front end assertions */
`timescale 1ns/1ns

module mem_ctl_properties (
	input logic                                 clk_i,
	input logic                                 rst_n_i,
	input logic                                 stall_i,
	input logic [mem_ctl_pkg::QUEUE_PTR_W-1:0]  wr_ptr_i,
	input logic                                 exec_valid_i,
	input logic                                 maint_valid_i,
	input mem_ctl_pkg::maint_cmd_t              maint_cmd_i,
	input logic                                 l2c_update_done_i
);

	// A full queue takes no write
	stall_blocks_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> $stable(wr_ptr_i))
		else $error("queue write while stall_o is high");

	// The sequencer spends at least one cycle after each issue
	valid_not_back_to_back: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		maint_valid_i |=> !maint_valid_i)
		else $error("maint_valid_o high on two consecutive cycles");

	// Sync only drops once the L2 has answered
	sync_held_until_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		maint_cmd_i.sync_l1dc_l2c && !l2c_update_done_i |=> maint_cmd_i.sync_l1dc_l2c)
		else $error("sync_l1dc_l2c dropped before l2c_update_done_i");

	outputs_quiet_in_reset: assert property (@(posedge clk_i)
		!rst_n_i |-> !exec_valid_i && !maint_valid_i && maint_cmd_i == '0 && !stall_i)
		else $error("output active during reset");

endmodule

// File: hdl/mem_ctl_top.sv
/* Load/store control front end */
`timescale 1ns/1ns

module mem_ctl_top (
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         ins_valid_i,
	input  logic [mem_ctl_pkg::ILEN-1:0] ins_i,
	input  logic                         except_valid_i,
	input  mem_ctl_pkg::except_code_e    except_code_i,
	input  logic                         l2c_update_done_i,
	output logic                         stall_o,
	output logic                         exec_valid_o,
	output mem_ctl_pkg::exec_hint_t      exec_hint_o,
	output logic                         maint_valid_o,
	output mem_ctl_pkg::maint_cmd_t      maint_cmd_o
);

	logic                    wr_en;
	mem_ctl_pkg::maint_req_t wr_req;
	logic                    rd_en;
	mem_ctl_pkg::maint_req_t rd_req;
	logic                    queue_empty;
	logic                    queue_full;

	// Queue full is the only back-pressure
	assign stall_o = queue_full;

	instr_decoder instr_decoder_i (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.ins_valid_i    (ins_valid_i),
		.ins_i          (ins_i),
		.except_valid_i (except_valid_i),
		.except_code_i  (except_code_i),
		.stall_i        (queue_full),
		.exec_valid_o   (exec_valid_o),
		.exec_hint_o    (exec_hint_o),
		.wr_en_o        (wr_en),
		.wr_req_o       (wr_req)
	);

	maint_req_queue maint_req_queue_i (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.wr_en_i  (wr_en),
		.wr_req_i (wr_req),
		.rd_en_i  (rd_en),
		.rd_req_o (rd_req),
		.empty_o  (queue_empty),
		.full_o   (queue_full)
	);

	maint_sequencer maint_sequencer_i (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.req_i             (rd_req),
		.empty_i           (queue_empty),
		.l2c_update_done_i (l2c_update_done_i),
		.rd_en_o           (rd_en),
		.maint_valid_o     (maint_valid_o),
		.maint_cmd_o       (maint_cmd_o)
	);

endmodule

// File: hdl/maint_sequencer.sv
/* Maintenance command sequencer */
`timescale 1ns/1ns

module maint_sequencer (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  mem_ctl_pkg::maint_req_t req_i,
	input  logic                    empty_i,
	input  logic                    l2c_update_done_i,
	output logic                    rd_en_o,
	output logic                    maint_valid_o,
	output mem_ctl_pkg::maint_cmd_t maint_cmd_o
);

	typedef enum logic [1:0] {
		ST_RESET,
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT_SYNC
	} seq_state_e;

	seq_state_e              state_q;
	seq_state_e              state_d;
	mem_ctl_pkg::maint_cmd_t cmd_d;
	logic                    valid_d;

	// Strobe set for one request kind
	function automatic mem_ctl_pkg::maint_cmd_t cmd_of(mem_ctl_pkg::maint_op_e op);
		mem_ctl_pkg::maint_cmd_t c;
		c = '0;
		case (op)
			mem_ctl_pkg::OP_FENCE_I: begin
				c.clr_tlb_mshr = 1'b1;
			end
			mem_ctl_pkg::OP_SFENCE_VMA: begin
				c.clr_tlb_mshr  = 1'b1;
				c.clr_dmshr     = 1'b1;
				c.tlb_flush     = mem_ctl_pkg::TLB_FLUSH_ALL;
				c.sync_l1dc_l2c = 1'b1;
			end
			mem_ctl_pkg::OP_EXC_INSTR: begin
				c.flush        = 1'b1;
				c.clr_tlb_mshr = 1'b1;
			end
			mem_ctl_pkg::OP_EXC_LDST: begin
				c.flush     = 1'b1;
				c.clr_dmshr = 1'b1;
			end
			mem_ctl_pkg::OP_EXC_ILLEGAL: begin
				c.flush = 1'b1;
				c.abort = 1'b1;
			end
			mem_ctl_pkg::OP_EXC_ECALL: begin
				c.flush         = 1'b1;
				c.sync_l1dc_l2c = 1'b1;
			end
			default: begin
				c.flush = 1'b1;
			end
		endcase
		return c;
	endfunction

	always_comb begin
		state_d = state_q;
		cmd_d   = '0;
		valid_d = 1'b0;
		rd_en_o = 1'b0;
		case (state_q)
			ST_RESET: begin
				// Full cleanup once after reset
				cmd_d.flush        = 1'b1;
				cmd_d.clr_tlb_mshr = 1'b1;
				cmd_d.clr_dmshr    = 1'b1;
				cmd_d.tlb_flush    = mem_ctl_pkg::TLB_FLUSH_ALL;
				valid_d            = 1'b1;
				state_d            = ST_ISSUE;
			end
			ST_IDLE: begin
				if (!empty_i) begin
					rd_en_o = 1'b1;
					cmd_d   = cmd_of(req_i.op);
					valid_d = 1'b1;
					state_d = ST_ISSUE;
				end
			end
			default: begin
				// Hold only sync until the L2 reports done
				if (maint_cmd_o.sync_l1dc_l2c && !l2c_update_done_i) begin
					cmd_d.sync_l1dc_l2c = 1'b1;
					state_d             = ST_WAIT_SYNC;
				end else begin
					state_d = ST_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q       <= ST_RESET;
			maint_valid_o <= 1'b0;
			maint_cmd_o   <= '0;
		end else begin
			state_q       <= state_d;
			maint_valid_o <= valid_d;
			maint_cmd_o   <= cmd_d;
		end
	end

endmodule

// File: hdl/maint_req_queue.sv
/* Maintenance request FIFO */
`timescale 1ns/1ns

module maint_req_queue (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    wr_en_i,
	input  mem_ctl_pkg::maint_req_t wr_req_i,
	input  logic                    rd_en_i,
	output mem_ctl_pkg::maint_req_t rd_req_o,
	output logic                    empty_o,
	output logic                    full_o
);

	mem_ctl_pkg::maint_req_t            mem [mem_ctl_pkg::QUEUE_DEPTH];
	logic [mem_ctl_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [mem_ctl_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [mem_ctl_pkg::QUEUE_PTR_W:0]   count;
	logic                                do_wr;
	logic                                do_rd;

	// Depth is a power of two, so the count MSB alone means full
	assign full_o  = count[mem_ctl_pkg::QUEUE_PTR_W];
	assign empty_o = (count == '0);

	// A pop in the same cycle frees the slot for the push
	assign do_rd = rd_en_i && !empty_o;
	assign do_wr = wr_en_i && (!full_o || rd_en_i);

	assign rd_req_o = mem[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_req_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/instr_decoder.sv
/* Instruction and exception decoder */
`timescale 1ns/1ns

module instr_decoder (
	input  logic                           clk_i,
	input  logic                           rst_n_i,
	input  logic                           ins_valid_i,
	input  logic [mem_ctl_pkg::ILEN-1:0]   ins_i,
	input  logic                           except_valid_i,
	input  mem_ctl_pkg::except_code_e      except_code_i,
	input  logic                           stall_i,
	output logic                           exec_valid_o,
	output mem_ctl_pkg::exec_hint_t        exec_hint_o,
	output logic                           wr_en_o,
	output mem_ctl_pkg::maint_req_t        wr_req_o
);

	mem_ctl_pkg::opcode_e    opcode;
	logic [2:0]              funct3;
	mem_ctl_pkg::exec_hint_t hint;
	logic                    hint_hit;
	mem_ctl_pkg::maint_op_e  ins_op;
	logic                    ins_req;
	mem_ctl_pkg::maint_op_e  exc_op;
	logic                    ins_take;

	assign opcode = mem_ctl_pkg::opcode_e'(ins_i[6:0]);
	assign funct3 = ins_i[14:12];

	// An exception in the same cycle discards the instruction
	assign ins_take = ins_valid_i && !except_valid_i && !stall_i;

	always_comb begin
		hint     = '{branch_type: mem_ctl_pkg::BR_BEQ, ldst_type: mem_ctl_pkg::LS_WORD,
			is_branch: 1'b0};
		hint_hit = 1'b0;
		ins_op   = mem_ctl_pkg::OP_FENCE_I;
		ins_req  = 1'b0;
		case (opcode)
			mem_ctl_pkg::OPC_BRANCH: begin
				hint_hit       = 1'b1;
				hint.is_branch = 1'b1;
				case (funct3)
					mem_ctl_pkg::F3_BNE:  hint.branch_type = mem_ctl_pkg::BR_BNE;
					mem_ctl_pkg::F3_BLT:  hint.branch_type = mem_ctl_pkg::BR_BLT;
					mem_ctl_pkg::F3_BLTU: hint.branch_type = mem_ctl_pkg::BR_BLTU;
					mem_ctl_pkg::F3_BGE:  hint.branch_type = mem_ctl_pkg::BR_BGE;
					mem_ctl_pkg::F3_BGEU: hint.branch_type = mem_ctl_pkg::BR_BGEU;
					default:              hint.branch_type = mem_ctl_pkg::BR_BEQ;
				endcase
			end
			mem_ctl_pkg::OPC_LOAD: begin
				hint_hit = 1'b1;
				case (funct3)
					mem_ctl_pkg::F3_LB:  hint.ldst_type = mem_ctl_pkg::LS_BYTE;
					mem_ctl_pkg::F3_LBU: hint.ldst_type = mem_ctl_pkg::LS_BYTE_U;
					mem_ctl_pkg::F3_LH:  hint.ldst_type = mem_ctl_pkg::LS_HALFWORD;
					mem_ctl_pkg::F3_LHU: hint.ldst_type = mem_ctl_pkg::LS_HALFWORD_U;
					mem_ctl_pkg::F3_LWU: hint.ldst_type = mem_ctl_pkg::LS_WORD_U;
					mem_ctl_pkg::F3_LD:  hint.ldst_type = mem_ctl_pkg::LS_DOUBLEWORD;
					mem_ctl_pkg::F3_LW:  hint.ldst_type = mem_ctl_pkg::LS_WORD;
					default:             hint.ldst_type = mem_ctl_pkg::LS_WORD;
				endcase
			end
			mem_ctl_pkg::OPC_STORE: begin
				hint_hit = 1'b1;
				case (funct3)
					mem_ctl_pkg::F3_SB: hint.ldst_type = mem_ctl_pkg::LS_BYTE;
					mem_ctl_pkg::F3_SH: hint.ldst_type = mem_ctl_pkg::LS_HALFWORD;
					mem_ctl_pkg::F3_SD: hint.ldst_type = mem_ctl_pkg::LS_DOUBLEWORD;
					mem_ctl_pkg::F3_SW: hint.ldst_type = mem_ctl_pkg::LS_WORD;
					default:            hint.ldst_type = mem_ctl_pkg::LS_WORD;
				endcase
			end
			mem_ctl_pkg::OPC_MISC_MEM: begin
				ins_req = (funct3 == mem_ctl_pkg::F3_FENCE_I);
			end
			mem_ctl_pkg::OPC_SYSTEM: begin
				// funct7 is not checked, any funct3 000 system word counts
				ins_req = (funct3 == mem_ctl_pkg::F3_SFENCE_VMA);
				ins_op  = mem_ctl_pkg::OP_SFENCE_VMA;
			end
			default: ;
		endcase
	end

	// Exception classes
	always_comb begin
		case (except_code_i)
			mem_ctl_pkg::EXC_I_MISALIGNED, mem_ctl_pkg::EXC_I_ACCESS_FAULT,
			mem_ctl_pkg::EXC_I_PAGE_FAULT:
				exc_op = mem_ctl_pkg::OP_EXC_INSTR;
			mem_ctl_pkg::EXC_LD_MISALIGNED, mem_ctl_pkg::EXC_LD_ACCESS_FAULT,
			mem_ctl_pkg::EXC_LD_PAGE_FAULT, mem_ctl_pkg::EXC_ST_MISALIGNED,
			mem_ctl_pkg::EXC_ST_ACCESS_FAULT, mem_ctl_pkg::EXC_ST_PAGE_FAULT:
				exc_op = mem_ctl_pkg::OP_EXC_LDST;
			mem_ctl_pkg::EXC_ILLEGAL_INSTR:
				exc_op = mem_ctl_pkg::OP_EXC_ILLEGAL;
			mem_ctl_pkg::EXC_ECALL_SMODE, mem_ctl_pkg::EXC_ECALL_MMODE:
				exc_op = mem_ctl_pkg::OP_EXC_ECALL;
			default:
				exc_op = mem_ctl_pkg::OP_EXC_OTHER;
		endcase
	end

	assign wr_en_o  = !stall_i && (except_valid_i || (ins_valid_i && ins_req));
	assign wr_req_o = '{op: (except_valid_i ? exc_op : ins_op)};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exec_valid_o <= 1'b0;
			exec_hint_o  <= '0;
		end else begin
			exec_valid_o <= ins_take && hint_hit;
			if (ins_take && hint_hit) begin
				exec_hint_o <= hint;
			end
		end
	end

endmodule

// File: hdl/mem_ctl_pkg.sv
/* Memory control shared definitions */
package mem_ctl_pkg;

	localparam int ILEN        = 32;
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

	// RV64 major opcodes seen by the decoder
	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_STORE    = 7'b0100011,
		OPC_BRANCH   = 7'b1100011,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	// Branch compares
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// Load widths
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LD  = 3'b011;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_LWU = 3'b110;

	// Store widths
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;
	localparam logic [2:0] F3_SD = 3'b011;

	localparam logic [2:0] F3_FENCE_I    = 3'b001;
	localparam logic [2:0] F3_SFENCE_VMA = 3'b000;

	// Standard RISC-V cause numbers
	typedef enum logic [3:0] {
		EXC_I_MISALIGNED   = 4'd0,
		EXC_I_ACCESS_FAULT = 4'd1,
		EXC_ILLEGAL_INSTR  = 4'd2,
		EXC_LD_MISALIGNED  = 4'd4,
		EXC_LD_ACCESS_FAULT = 4'd5,
		EXC_ST_MISALIGNED  = 4'd6,
		EXC_ST_ACCESS_FAULT = 4'd7,
		EXC_ECALL_SMODE    = 4'd9,
		EXC_ECALL_MMODE    = 4'd11,
		EXC_I_PAGE_FAULT   = 4'd12,
		EXC_LD_PAGE_FAULT  = 4'd13,
		EXC_ST_PAGE_FAULT  = 4'd15
	} except_code_e;

	typedef enum logic [2:0] {
		BR_BEQ, BR_BNE, BR_BLT, BR_BLTU, BR_BGE, BR_BGEU
	} branch_type_e;

	typedef enum logic [2:0] {
		LS_BYTE, LS_BYTE_U, LS_HALFWORD, LS_HALFWORD_U, LS_WORD, LS_WORD_U, LS_DOUBLEWORD
	} ldst_type_e;

	typedef enum logic {
		TLB_NO_FLUSH,
		TLB_FLUSH_ALL
	} tlb_flush_e;

	typedef enum logic [2:0] {
		OP_FENCE_I, OP_SFENCE_VMA, OP_EXC_INSTR, OP_EXC_LDST,
		OP_EXC_ILLEGAL, OP_EXC_ECALL, OP_EXC_OTHER
	} maint_op_e;

	typedef struct packed {
		branch_type_e branch_type;
		ldst_type_e   ldst_type;
		logic         is_branch;
	} exec_hint_t;

	typedef struct packed {
		maint_op_e op;
	} maint_req_t;

	typedef struct packed {
		logic       flush;
		logic       abort;
		logic       clr_tlb_mshr;
		logic       clr_dmshr;
		logic       sync_l1dc_l2c;
		tlb_flush_e tlb_flush;
	} maint_cmd_t;

endpackage
